// File: Makefile
VERILATOR  ?= verilator
TOP        ?= gat_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the simulator output
run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/gat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gat_tb;

  localparam int CLK_HALF    = 10;
  localparam int READY_WAIT  = 2000;
  localparam int FALL_WAIT   = 20;
  localparam int SLOPE_SHIFT = 3;
  localparam int NODES       = gat_pkg::NUM_NODES;
  localparam int F_IN        = gat_pkg::NUM_FEATURE_IN;
  localparam int F_OUT       = gat_pkg::NUM_FEATURE_OUT;
  localparam int SLOTS       = gat_pkg::FEAT_SLOTS;
  localparam int A_WORD      = F_IN * F_OUT;
  localparam int W_WORDS     = A_WORD + F_OUT;

  logic        clk;
  logic        rst_n;
  logic        h_data_done;
  logic        node_info_done;
  logic        wgt_done;
  logic [31:0] h_din;
  logic        h_ena;
  logic        h_wea;
  logic [7:0]  h_addra;
  logic [31:0] wgt_din;
  logic        wgt_ena;
  logic        wgt_wea;
  logic [7:0]  wgt_addra;
  logic [7:0]  feat_addrb;
  logic [31:0] feat_dout;
  logic        gat_ready;
  logic [31:0] gat_debug_1;
  logic [31:0] gat_debug_2;
  logic [2:0]  flags;

  int checks;
  int value_errors;
  int other_errors;

  // Reference model state
  int h_m [NODES][F_IN];
  int w_m [F_IN][F_OUT];
  int a_m [F_OUT];
  int wh_m [NODES][F_OUT];
  int score_m [NODES];

  assign flags = {h_data_done, node_info_done, wgt_done};

  gat_top_wrapper uut (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .gat_ready                  (gat_ready),
    .gat_debug_1                (gat_debug_1),
    .gat_debug_2                (gat_debug_2),
    .h_data_bram_load_done      (h_data_done),
    .h_node_info_bram_load_done (node_info_done),
    .wgt_bram_load_done         (wgt_done),
    .h_data_bram_din            (h_din),
    .h_data_bram_ena            (h_ena),
    .h_data_bram_wea            (h_wea),
    .h_data_bram_addra          (h_addra),
    .wgt_bram_din               (wgt_din),
    .wgt_bram_ena               (wgt_ena),
    .wgt_bram_wea               (wgt_wea),
    .wgt_bram_addra             (wgt_addra),
    .feat_bram_addrb            (feat_addrb),
    .feat_bram_dout             (feat_dout)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ============================
  // Protocol checks
  // ============================
  // Ready falls the cycle after any flag drops
  assert property (@(posedge clk) disable iff (!rst_n) !(&flags) |=> !gat_ready)
    else begin
      value_errors++;
      $display("error gat_ready expected %h got %h", 1'b0, gat_ready);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready |-> (gat_debug_1 == 32'(NODES)) && (gat_debug_2 == 32'(NODES)))
    else begin
      value_errors++;
      $display("error gat_debug_1 expected %h got %h, gat_debug_2 expected %h got %h",
               32'(NODES), gat_debug_1, 32'(NODES), gat_debug_2);
    end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      value_errors++;
      $display("error %s expected %h got %h", name, expected, actual);
    end
  endtask

  // ============================
  // Reference model
  // ============================
  function automatic int small_value();
    return int'($urandom % 16) - 8;
  endfunction

  function automatic void draw_data();
    for (int n = 0; n < NODES; n++)
      for (int i = 0; i < F_IN; i++)
        h_m[n][i] = small_value();
    for (int i = 0; i < F_IN; i++)
      for (int o = 0; o < F_OUT; o++)
        w_m[i][o] = small_value();
    for (int o = 0; o < F_OUT; o++)
      a_m[o] = small_value();
  endfunction

  function automatic void compute_model();
    int dot;
    for (int n = 0; n < NODES; n++) begin
      dot = 0;
      for (int o = 0; o < F_OUT; o++) begin
        wh_m[n][o] = 0;
        for (int i = 0; i < F_IN; i++)
          wh_m[n][o] += h_m[n][i] * w_m[i][o];
        dot += a_m[o] * wh_m[n][o];
      end
      // LeakyReLU with a 1/8 negative slope
      score_m[n] = (dot < 0) ? (dot >>> SLOPE_SHIFT) : dot;
    end
  endfunction

  function automatic bit scores_mixed();
    bit neg;
    bit pos;
    neg = 1'b0;
    pos = 1'b0;
    for (int n = 0; n < NODES; n++) begin
      if (score_m[n] < 0)
        neg = 1'b1;
      else
        pos = 1'b1;
    end
    return neg && pos;
  endfunction

  // W row-major, then a
  function automatic int weight_word(input int k);
    if (k < A_WORD)
      return w_m[k / F_OUT][k % F_OUT];
    else if (k < W_WORDS)
      return a_m[k - A_WORD];
    return 0;
  endfunction

  function automatic int expected_word(input int n, input int s);
    if (s < F_OUT)
      return wh_m[n][s];
    else if (s == F_OUT)
      return score_m[n];
    return 0;
  endfunction

  // ============================
  // Host side tasks
  // ============================
  // H and weight ports load side by side
  task automatic load_memories();
    for (int k = 0; k < NODES * F_IN; k++) begin
      @(posedge clk);
      h_ena     <= 1'b1;
      h_wea     <= 1'b1;
      h_addra   <= 8'(k * 4);
      h_din     <= 32'(h_m[k / F_IN][k % F_IN]);
      wgt_ena   <= (k < W_WORDS);
      wgt_wea   <= (k < W_WORDS);
      wgt_addra <= 8'(k * 4);
      wgt_din   <= 32'(weight_word(k));
    end
    @(posedge clk);
    h_ena   <= 1'b0;
    h_wea   <= 1'b0;
    wgt_ena <= 1'b0;
    wgt_wea <= 1'b0;
  endtask

  task automatic check_readback();
    logic [31:0] got;
    for (int n = 0; n < NODES; n++) begin
      for (int s = 0; s < SLOTS; s++) begin
        @(posedge clk);
        feat_addrb <= 8'((n * SLOTS + s) * 4);
        @(posedge clk);
        @(negedge clk);
        got = feat_dout;
        check_value($sformatf("feat_bram_dout node %0d slot %0d", n, s),
                    32'(expected_word(n, s)), got);
      end
    end
  endtask

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    while (gat_ready !== 1'b1 && cycles < READY_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (gat_ready !== 1'b1) begin
      other_errors++;
      $display("gat_ready did not rise within %0d cycles", READY_WAIT);
    end
  endtask

  task automatic wait_for_drop();
    int cycles;
    cycles = 0;
    while (gat_ready !== 1'b0 && cycles < FALL_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (gat_ready !== 1'b0) begin
      other_errors++;
      $display("gat_ready stayed high after a load flag dropped");
    end
  endtask

  task automatic run_layer(input int run_idx);
    int tries;
    tries = 0;
    // Redraw until scores of both signs occur
    do begin
      draw_data();
      compute_model();
      tries++;
    end while (!scores_mixed() && tries < 50);
    if (!scores_mixed()) begin
      other_errors++;
      $display("run %0d found no data with scores of both signs", run_idx);
    end
    load_memories();
    @(posedge clk);
    h_data_done    <= 1'b1;
    node_info_done <= 1'b1;
    wgt_done       <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_value("gat_debug_1", 32'd0, gat_debug_1);
    check_value("gat_debug_2", 32'd0, gat_debug_2);
    wait_for_ready();
    check_value("gat_debug_1", 32'(NODES), gat_debug_1);
    check_value("gat_debug_2", 32'(NODES), gat_debug_2);
    check_readback();
    // One flag is enough to end the run
    @(posedge clk);
    node_info_done <= 1'b0;
    wait_for_drop();
    @(posedge clk);
    h_data_done <= 1'b0;
    wgt_done    <= 1'b0;
  endtask

  initial begin
    void'($urandom(21));
    checks         = 0;
    value_errors   = 0;
    other_errors   = 0;
    rst_n          = 1'b0;
    h_data_done    = 1'b0;
    node_info_done = 1'b0;
    wgt_done       = 1'b0;
    h_din          = '0;
    h_ena          = 1'b0;
    h_wea          = 1'b0;
    h_addra        = '0;
    wgt_din        = '0;
    wgt_ena        = 1'b0;
    wgt_wea        = 1'b0;
    wgt_addra      = '0;
    feat_addrb     = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("gat_ready", 32'd0, 32'(gat_ready));
    check_value("gat_debug_1", 32'd0, gat_debug_1);
    check_value("gat_debug_2", 32'd0, gat_debug_2);
    // No flags, core stays idle
    repeat (10) begin
      @(negedge clk);
      check_value("gat_ready", 32'd0, 32'(gat_ready));
    end
    run_layer(1);
    run_layer(2);
    $display("checks %0d, value errors %0d, other failures %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/gat_pkg.sv
source/gat_bram.sv
source/gat_wh_producer.sv
source/gat_wh_fifo.sv
source/gat_attn_consumer.sv
source/gat_top_wrapper.sv
bench/gat_tb.sv

// File: source/gat_attn_consumer.sv
`timescale 1ns/1ps
`default_nettype none

module gat_attn_consumer (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  gat_pkg::flags_t      load_done,
  input  gat_pkg::bram_wr_t    wgt_wr,
  input  wire logic            vec_valid,
  input  gat_pkg::wh_vec_t     head_vec,
  output logic                 vec_pop,
  output gat_pkg::bram_wr_t    feat_wr,
  output logic                 gat_ready,
  output gat_pkg::cnt_t        nodes_done
);

  gat_pkg::cons_state_t state_q;
  gat_pkg::data_t       a_q [gat_pkg::NUM_FEATURE_OUT];
  gat_pkg::bram_addr_t  a_off;
  logic                 a_hit;
  gat_pkg::wh_vec_t     cur_q;
  gat_pkg::score_t      score_q;
  gat_pkg::score_t      dot;
  gat_pkg::score_t      leaky;
  gat_pkg::feat_idx_t   slot_q;
  gat_pkg::word_t       slot_data;

  // ============================
  // Snoop a from weight writes
  // ============================
  // Addresses below A_BASE wrap high and miss
  assign a_off = wgt_wr.addr - gat_pkg::bram_addr_t'(gat_pkg::A_BASE);
  assign a_hit = wgt_wr.ena && wgt_wr.wea &&
                 (a_off[gat_pkg::BRAM_ADDR_W-1:gat_pkg::OUT_IDX_W] == '0);

  // Score of the head vector
  always_comb begin
    dot = '0;
    for (int i = 0; i < gat_pkg::NUM_FEATURE_OUT; i++) begin
      dot = dot + gat_pkg::score_t'(a_q[i]) * gat_pkg::score_t'(head_vec.wh[i]);
    end
  end

  // LeakyReLU with a negative slope of 1/8
  assign leaky = dot[gat_pkg::SCORE_WIDTH-1] ? (dot >>> gat_pkg::LEAKY_SHIFT) : dot;

  always_ff @(posedge clk) begin
    if (a_hit) begin
      a_q[a_off[gat_pkg::OUT_IDX_W-1:0]] <=
        gat_pkg::data_t'(wgt_wr.data[gat_pkg::DATA_WIDTH-1:0]);
    end
    if (vec_pop) begin
      cur_q   <= head_vec;
      score_q <= leaky;
    end
  end

  // ============================
  // Per-node write burst
  // ============================
  // Wh in slots 0-3 and the score in slot 4 with zeros above
  always_comb begin
    if (slot_q < gat_pkg::SCORE_SLOT) begin
      slot_data = gat_pkg::word_t'(gat_pkg::score_t'(cur_q.wh[slot_q[gat_pkg::OUT_IDX_W-1:0]]));
    end else if (slot_q == gat_pkg::SCORE_SLOT) begin
      slot_data = gat_pkg::word_t'(score_q);
    end else begin
      slot_data = '0;
    end
  end

  assign vec_pop      = (state_q == gat_pkg::C_IDLE) && vec_valid;
  assign feat_wr.ena  = (state_q == gat_pkg::C_WRITE);
  assign feat_wr.wea  = feat_wr.ena;
  assign feat_wr.addr = gat_pkg::bram_addr_t'(cur_q.node * gat_pkg::FEAT_SLOTS + slot_q);
  assign feat_wr.data = slot_data;
  assign gat_ready    = (state_q == gat_pkg::C_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= gat_pkg::C_IDLE;
      slot_q     <= '0;
      nodes_done <= '0;
    end else begin
      case (state_q)
        gat_pkg::C_IDLE: begin
          if (vec_valid) begin
            state_q <= gat_pkg::C_WRITE;
            slot_q  <= '0;
          end
        end
        gat_pkg::C_WRITE: begin
          slot_q <= slot_q + 1'b1;
          if (slot_q == gat_pkg::LAST_SLOT) begin
            nodes_done <= nodes_done + 1'b1;
            state_q    <= (cur_q.node == gat_pkg::LAST_NODE) ? gat_pkg::C_DONE : gat_pkg::C_IDLE;
          end
        end
        // Any flag drop ends the run
        gat_pkg::C_DONE: begin
          if (!(&load_done)) begin
            state_q    <= gat_pkg::C_IDLE;
            nodes_done <= '0;
          end
        end
        default: state_q <= gat_pkg::C_IDLE;
      endcase
    end
  end

  // Nodes leave the FIFO in order
  assert property (@(posedge clk) disable iff (!rst_n)
    vec_pop |-> (head_vec.node == gat_pkg::node_idx_t'(nodes_done)));

  // Ready means every node burst has landed
  assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready |-> (nodes_done == gat_pkg::ALL_NODES));

endmodule

`default_nettype wire

// File: source/gat_bram.sv
`timescale 1ns/1ps
`default_nettype none

module gat_bram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32
) (
  input  wire logic                clk,
  input  gat_pkg::bram_wr_t        wr,
  input  gat_pkg::bram_addr_t      addrb,
  output logic [WIDTH-1:0]         doutb
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic             wr_en;
  logic             in_range;

  // ============================
  // Write port
  // ============================
  // Words past DEPTH are dropped, the address space is shared
  assign in_range = int'(wr.addr) < DEPTH;
  assign wr_en    = wr.ena && wr.wea && in_range;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      // Narrow memories keep the low bits of the host word
      mem[wr.addr] <= wr.data[WIDTH-1:0];
    end
  end

  // ============================
  // Read port
  // ============================
  // One cycle latency
  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
  end

endmodule

`default_nettype wire

// File: source/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // ============================
  // Layer sizes
  // ============================
  localparam int NUM_NODES          = 8;
  localparam int NUM_FEATURE_IN     = 8;
  localparam int NUM_FEATURE_OUT    = 4;
  localparam int DATA_WIDTH         = 8;
  localparam int WH_DATA_WIDTH      = 20;
  localparam int SCORE_WIDTH        = 32;
  localparam int NEW_FEATURE_WIDTH  = 32;
  localparam int TOP_WIDTH          = 32;
  localparam int NUM_FLAGS          = 3;
  localparam int LEAKY_SHIFT        = 3;

  // ============================
  // Memory map
  // ============================
  localparam int H_DATA_DEPTH       = NUM_NODES * NUM_FEATURE_IN;
  localparam int H_DATA_ADDR_W      = $clog2(H_DATA_DEPTH);
  // a follows the row-major W block
  localparam int A_BASE             = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int WEIGHT_DEPTH       = A_BASE + NUM_FEATURE_OUT;
  localparam int WEIGHT_ADDR_W      = $clog2(WEIGHT_DEPTH);
  localparam int FEAT_SLOTS         = 8;
  localparam int NEW_FEATURE_DEPTH  = NUM_NODES * FEAT_SLOTS;
  localparam int NEW_FEATURE_ADDR_W = $clog2(NEW_FEATURE_DEPTH);
  localparam int WH_FIFO_DEPTH      = 4;

  // Shared word address width for all three memories
  localparam int BRAM_ADDR_W        = (H_DATA_ADDR_W > WEIGHT_ADDR_W) ?
                                      H_DATA_ADDR_W : WEIGHT_ADDR_W;
  localparam int OUT_IDX_W          = $clog2(NUM_FEATURE_OUT);
  localparam int CNT_W              = $clog2(NUM_NODES + 1);

  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_data_t;
  typedef logic signed [SCORE_WIDTH-1:0]   score_t;
  typedef logic [$clog2(NUM_NODES)-1:0]    node_idx_t;
  typedef logic [$clog2(FEAT_SLOTS)-1:0]   feat_idx_t;
  typedef logic [OUT_IDX_W-1:0]            out_idx_t;
  typedef logic [CNT_W-1:0]                cnt_t;
  typedef logic [NUM_FLAGS-1:0]            flags_t;
  typedef logic [TOP_WIDTH-1:0]            word_t;
  typedef logic [BRAM_ADDR_W-1:0]          bram_addr_t;
  typedef logic [$clog2(WH_FIFO_DEPTH)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(WH_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // Loop limits and fixed slots
  localparam node_idx_t LAST_NODE  = node_idx_t'(NUM_NODES - 1);
  localparam feat_idx_t LAST_IN    = feat_idx_t'(NUM_FEATURE_IN - 1);
  localparam out_idx_t  LAST_OUT   = out_idx_t'(NUM_FEATURE_OUT - 1);
  localparam feat_idx_t SCORE_SLOT = feat_idx_t'(NUM_FEATURE_OUT);
  localparam feat_idx_t LAST_SLOT  = feat_idx_t'(FEAT_SLOTS - 1);
  localparam fifo_cnt_t FIFO_FULL  = fifo_cnt_t'(WH_FIFO_DEPTH);
  localparam cnt_t      ALL_NODES  = cnt_t'(NUM_NODES);

  typedef struct packed {
    logic       ena;
    logic       wea;
    bram_addr_t addr;
    word_t      data;
  } bram_wr_t;

  typedef struct packed {
    node_idx_t                           node;
    wh_data_t [NUM_FEATURE_OUT-1:0]      wh;
  } wh_vec_t;

  typedef enum logic [2:0] {
    P_IDLE,
    P_READ,
    P_ACC,
    P_EMIT,
    P_DONE
  } prod_state_t;

  typedef enum logic [1:0] {
    C_IDLE,
    C_WRITE,
    C_DONE
  } cons_state_t;

endpackage

`default_nettype wire

// File: source/gat_top_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module gat_top_wrapper (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,

  // ============================
  // Register bank
  // ============================
  output logic                                      gat_ready,
  output logic [gat_pkg::TOP_WIDTH-1:0]             gat_debug_1,
  output logic [gat_pkg::TOP_WIDTH-1:0]             gat_debug_2,
  input  wire logic                                 h_data_bram_load_done,
  input  wire logic                                 h_node_info_bram_load_done,
  input  wire logic                                 wgt_bram_load_done,

  // ============================
  // BRAM ports, byte addressed
  // ============================
  input  wire logic [gat_pkg::TOP_WIDTH-1:0]        h_data_bram_din,
  input  wire logic                                 h_data_bram_ena,
  input  wire logic                                 h_data_bram_wea,
  input  wire logic [gat_pkg::H_DATA_ADDR_W+1:0]    h_data_bram_addra,

  input  wire logic [gat_pkg::TOP_WIDTH-1:0]        wgt_bram_din,
  input  wire logic                                 wgt_bram_ena,
  input  wire logic                                 wgt_bram_wea,
  input  wire logic [gat_pkg::WEIGHT_ADDR_W+1:0]    wgt_bram_addra,

  input  wire logic [gat_pkg::NEW_FEATURE_ADDR_W+1:0] feat_bram_addrb,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]     feat_bram_dout
);

  gat_pkg::flags_t     load_done;
  gat_pkg::bram_wr_t   h_wr;
  gat_pkg::bram_wr_t   wgt_wr;
  gat_pkg::bram_wr_t   feat_wr;
  gat_pkg::bram_addr_t h_addr;
  gat_pkg::bram_addr_t w_addr;
  gat_pkg::data_t      h_dout;
  gat_pkg::data_t      w_dout;
  logic                wh_valid;
  logic                wh_ready;
  gat_pkg::wh_vec_t    wh_vec;
  logic                vec_valid;
  logic                vec_pop;
  gat_pkg::wh_vec_t    head_vec;
  gat_pkg::cnt_t       nodes_emitted;
  gat_pkg::cnt_t       nodes_done;

  // Node info flag has no memory behind it here
  assign load_done = {h_data_bram_load_done, h_node_info_bram_load_done, wgt_bram_load_done};

  // Byte to word addresses
  assign h_wr   = '{ena: h_data_bram_ena, wea: h_data_bram_wea,
                    addr: h_data_bram_addra[gat_pkg::H_DATA_ADDR_W+1:2], data: h_data_bram_din};
  assign wgt_wr = '{ena: wgt_bram_ena, wea: wgt_bram_wea,
                    addr: wgt_bram_addra[gat_pkg::WEIGHT_ADDR_W+1:2], data: wgt_bram_din};

  assign gat_debug_1 = {{(gat_pkg::TOP_WIDTH - gat_pkg::CNT_W){1'b0}}, nodes_emitted};
  assign gat_debug_2 = {{(gat_pkg::TOP_WIDTH - gat_pkg::CNT_W){1'b0}}, nodes_done};

  gat_bram #(.DEPTH(gat_pkg::H_DATA_DEPTH), .WIDTH(gat_pkg::DATA_WIDTH)) u_h_bram (
    .clk   (clk),
    .wr    (h_wr),
    .addrb (h_addr),
    .doutb (h_dout)
  );

  gat_bram #(.DEPTH(gat_pkg::WEIGHT_DEPTH), .WIDTH(gat_pkg::DATA_WIDTH)) u_w_bram (
    .clk   (clk),
    .wr    (wgt_wr),
    .addrb (w_addr),
    .doutb (w_dout)
  );

  gat_bram #(.DEPTH(gat_pkg::NEW_FEATURE_DEPTH), .WIDTH(gat_pkg::NEW_FEATURE_WIDTH)) u_feat_bram (
    .clk   (clk),
    .wr    (feat_wr),
    .addrb (feat_bram_addrb[gat_pkg::NEW_FEATURE_ADDR_W+1:2]),
    .doutb (feat_bram_dout)
  );

  gat_wh_producer u_producer (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_done     (load_done),
    .h_addr        (h_addr),
    .h_dout        (h_dout),
    .w_addr        (w_addr),
    .w_dout        (w_dout),
    .wh_valid      (wh_valid),
    .wh_vec        (wh_vec),
    .wh_ready      (wh_ready),
    .nodes_emitted (nodes_emitted)
  );

  gat_wh_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (wh_valid),
    .push_vec (wh_vec),
    .ready    (wh_ready),
    .pop      (vec_pop),
    .head_vec (head_vec),
    .valid    (vec_valid)
  );

  gat_attn_consumer u_consumer (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_done  (load_done),
    .wgt_wr     (wgt_wr),
    .vec_valid  (vec_valid),
    .head_vec   (head_vec),
    .vec_pop    (vec_pop),
    .feat_wr    (feat_wr),
    .gat_ready  (gat_ready),
    .nodes_done (nodes_done)
  );

endmodule

`default_nettype wire

// File: source/gat_wh_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module gat_wh_fifo (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          push,
  input  gat_pkg::wh_vec_t   push_vec,
  output logic               ready,
  input  wire logic          pop,
  output gat_pkg::wh_vec_t   head_vec,
  output logic               valid
);

  gat_pkg::wh_vec_t   mem [gat_pkg::WH_FIFO_DEPTH];
  gat_pkg::fifo_ptr_t wr_ptr_q;
  gat_pkg::fifo_ptr_t rd_ptr_q;
  gat_pkg::fifo_cnt_t count_q;
  logic               wr_en;
  logic               rd_en;

  assign ready    = (count_q != gat_pkg::FIFO_FULL);
  assign valid    = (count_q != '0);
  assign wr_en    = push && ready;
  assign rd_en    = pop && valid;
  assign head_vec = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= push_vec;
    end
  end

  // Pointers wrap at the power-of-two depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // No push lands on a full FIFO, so the write side only laps the read side
  assert property (@(posedge clk) disable iff (!rst_n)
    !ready |-> (wr_ptr_q == rd_ptr_q));

  // Consumer only takes a vector that is there
  assert property (@(posedge clk) disable iff (!rst_n) pop |-> valid);

endmodule

`default_nettype wire

// File: source/gat_wh_producer.sv
`timescale 1ns/1ps
`default_nettype none

module gat_wh_producer (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  gat_pkg::flags_t        load_done,
  output gat_pkg::bram_addr_t    h_addr,
  input  gat_pkg::data_t         h_dout,
  output gat_pkg::bram_addr_t    w_addr,
  input  gat_pkg::data_t         w_dout,
  output logic                   wh_valid,
  output gat_pkg::wh_vec_t       wh_vec,
  input  wire logic              wh_ready,
  output gat_pkg::cnt_t          nodes_emitted
);

  gat_pkg::prod_state_t state_q;
  gat_pkg::node_idx_t   node_q;
  gat_pkg::out_idx_t    out_q;
  gat_pkg::feat_idx_t   in_q;
  logic                 mac_en_q;
  logic                 first_q;
  logic                 start;
  logic signed [2*gat_pkg::DATA_WIDTH-1:0] prod;
  gat_pkg::wh_data_t    acc_q;
  gat_pkg::wh_data_t    acc_base;
  gat_pkg::wh_data_t    sum_next;

  assign start = &load_done;

  // H row of this node, W row of this input, column of this output
  assign h_addr = gat_pkg::bram_addr_t'(node_q * gat_pkg::NUM_FEATURE_IN + in_q);
  assign w_addr = gat_pkg::bram_addr_t'(in_q * gat_pkg::NUM_FEATURE_OUT + out_q);

  // ============================
  // MAC, one cycle behind reads
  // ============================
  assign prod     = h_dout * w_dout;
  assign acc_base = first_q ? '0 : acc_q;
  assign sum_next = acc_base + gat_pkg::wh_data_t'(prod);

  assign wh_valid = (state_q == gat_pkg::P_EMIT);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q       <= gat_pkg::P_IDLE;
      node_q        <= '0;
      out_q         <= '0;
      in_q          <= '0;
      mac_en_q      <= 1'b0;
      first_q       <= 1'b0;
      nodes_emitted <= '0;
    end else begin
      mac_en_q <= 1'b0;
      case (state_q)
        gat_pkg::P_IDLE: begin
          if (start) begin
            state_q       <= gat_pkg::P_READ;
            node_q        <= '0;
            out_q         <= '0;
            in_q          <= '0;
            nodes_emitted <= '0;
          end
        end
        gat_pkg::P_READ: begin
          mac_en_q <= 1'b1;
          first_q  <= (in_q == '0);
          in_q     <= in_q + 1'b1;
          if (in_q == gat_pkg::LAST_IN) begin
            state_q <= gat_pkg::P_ACC;
          end
        end
        // Last product lands here
        gat_pkg::P_ACC: begin
          out_q   <= out_q + 1'b1;
          state_q <= (out_q == gat_pkg::LAST_OUT) ? gat_pkg::P_EMIT : gat_pkg::P_READ;
        end
        gat_pkg::P_EMIT: begin
          if (wh_ready) begin
            nodes_emitted <= nodes_emitted + 1'b1;
            if (node_q == gat_pkg::LAST_NODE) begin
              state_q <= gat_pkg::P_DONE;
            end else begin
              node_q  <= node_q + 1'b1;
              state_q <= gat_pkg::P_READ;
            end
          end
        end
        gat_pkg::P_DONE: begin
          if (!start) begin
            state_q <= gat_pkg::P_IDLE;
          end
        end
        default: state_q <= gat_pkg::P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mac_en_q) begin
      acc_q <= sum_next;
    end
    if (state_q == gat_pkg::P_ACC) begin
      wh_vec.wh[out_q] <= sum_next;
      wh_vec.node      <= node_q;
    end
  end

  // Offer holds until the FIFO takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid && !wh_ready |=> wh_valid && $stable(wh_vec));

endmodule

`default_nettype wire
